// File: fabricBusPkg.sv
package fabricBusPkg;

    // ----------------------------------------------------------------------
    // Host bus fields
    // ----------------------------------------------------------------------

    // Byte address over the 128 KB aperture
    localparam int busAddrWidth = 17;
    localparam int busDataWidth = 32;
    // One strobe per data byte
    localparam int byteLanes = busDataWidth / 8;

    typedef logic [busAddrWidth-1:0] busAddr_t;
    typedef logic [busDataWidth-1:0] busData_t;
    typedef logic [byteLanes-1:0]    byteStb_t;

    // ----------------------------------------------------------------------
    // Region map
    // ----------------------------------------------------------------------

    // Address bits 16 to 13 pick the region
    localparam int regionLsb = 13;

    typedef logic [busAddrWidth-regionLsb-1:0] regionSel_t;

    // Region field values, 8 KB apart
    localparam regionSel_t regBase      = regionSel_t'(0);
    localparam regionSel_t ram0Base     = regionSel_t'(1);
    localparam regionSel_t ram1Base     = regionSel_t'(2);
    localparam regionSel_t reservedBase = regionSel_t'(4);

    // Word addresses inside a region
    localparam int ramAddrWidth = 11;
    localparam int ramDepth     = 1 << ramAddrWidth;
    localparam int regAddrWidth = 7;

    typedef logic [ramAddrWidth-1:0] ramAddr_t;
    typedef logic [regAddrWidth-1:0] regAddr_t;

    // ----------------------------------------------------------------------
    // Unmapped access handling
    // ----------------------------------------------------------------------

    // Read value when no region answers
    localparam busData_t badAccessValue = 32'hBADFABAC;
    localparam int timeoutWidth = 3;
    localparam logic [timeoutWidth-1:0] timeoutCount = 3'd7;

endpackage

// File: fabricIdPkg.sv
package fabricIdPkg;

    // ----------------------------------------------------------------------
    // Fabric register bank
    // ----------------------------------------------------------------------

    // Word offsets inside the register region
    localparam logic [6:0] idRegOfs   = 7'h00;
    localparam logic [6:0] revRegOfs  = 7'h01;
    localparam logic [6:0] gpioInOfs  = 7'h02;
    localparam logic [6:0] gpioOutOfs = 7'h03;
    localparam logic [6:0] gpioOeOfs  = 7'h04;

    localparam logic [31:0] fabricIdValue  = 32'h0000AC3B;
    localparam logic [31:0] fabricRevValue = 32'h00000100;

    // GPIO width and reset state
    localparam int gpioWidth = 8;
    typedef logic [gpioWidth-1:0] gpio_t;
    localparam gpio_t gpioOutRstValue = 8'h00;
    localparam gpio_t gpioOeRstValue  = 8'h00;

    // Marks a read of an undefined offset
    localparam logic [31:0] regUndefValue = 32'hFABDEFAC;

    // ----------------------------------------------------------------------
    // Reserved identification block
    // ----------------------------------------------------------------------

    localparam logic [6:0] custProdOfs  = 7'h7E;
    localparam logic [6:0] revisionsOfs = 7'h7F;
    localparam logic [7:0]  customerId = 8'h01;
    localparam logic [7:0]  productId  = 8'h00;
    localparam logic [15:0] majorRev   = 16'h0001;
    localparam logic [15:0] minorRev   = 16'h0000;
    localparam logic [31:0] reservedUndefValue = 32'hDEFFABAC;

endpackage

// File: busDecoder.sv
`timescale 1ns/1ps

module busDecoder
(
    input  logic                   wbClk_i,
    input  logic                   reset_i,
    input  logic                   cyc_i,
    input  logic                   stb_i,
    input  fabricBusPkg::busAddr_t addr_i,
    input  logic                   regAck_i,
    input  logic                   ram0Ack_i,
    input  logic                   ram1Ack_i,
    input  logic                   resAck_i,
    input  fabricBusPkg::busData_t regData_i,
    input  fabricBusPkg::busData_t ram0Data_i,
    input  fabricBusPkg::busData_t ram1Data_i,
    input  fabricBusPkg::busData_t resData_i,
    output logic                   regSel_o,
    output logic                   ram0Sel_o,
    output logic                   ram1Sel_o,
    output logic                   resSel_o,
    output logic                   ack_o,
    output fabricBusPkg::busData_t rdData_o
);

    import fabricBusPkg::*;

    regionSel_t              region;
    logic                    cycStb;
    logic                    datapathAck;
    logic                    timeoutAck;
    logic [timeoutWidth-1:0] timeoutCnt;

    // ----------------------------------------------------------------------
    // Region select
    // ----------------------------------------------------------------------

    assign region = addr_i[busAddrWidth-1:regionLsb];
    assign cycStb = cyc_i & stb_i;

    // One select per mapped region
    assign regSel_o  = cycStb & (region == regBase);
    assign ram0Sel_o = cycStb & (region == ram0Base);
    assign ram1Sel_o = cycStb & (region == ram1Base);
    assign resSel_o  = cycStb & (region == reservedBase);

    // Merged acknowledge, timeout included
    assign datapathAck = regAck_i | ram0Ack_i | ram1Ack_i | resAck_i;
    assign ack_o       = datapathAck | timeoutAck;

    // ----------------------------------------------------------------------
    // Timeout for cycles nobody answers
    // ----------------------------------------------------------------------

    always_ff @(posedge wbClk_i)
    begin
        if (reset_i)
        begin
            timeoutCnt <= '0;
            timeoutAck <= 1'b0;
        end
        // Idle bus or any acknowledge restarts the count
        else if (!cycStb || ack_o)
        begin
            timeoutCnt <= '0;
            timeoutAck <= 1'b0;
        end
        else if (timeoutCnt == timeoutCount)
        begin
            timeoutCnt <= '0;
            timeoutAck <= 1'b1;
        end
        else
        begin
            timeoutCnt <= timeoutCnt + 1'b1;
            timeoutAck <= 1'b0;
        end
    end

    // Read data steering
    always_comb
    begin
        case (region)
            regBase:      rdData_o = regData_i;
            ram0Base:     rdData_o = ram0Data_i;
            ram1Base:     rdData_o = ram1Data_i;
            reservedBase: rdData_o = resData_i;
            default:      rdData_o = badAccessValue;
        endcase
    end

endmodule

// File: fabricRegisters.sv
`timescale 1ns/1ps

module fabricRegisters
(
    input  logic                   wbClk_i,
    input  logic                   reset_i,
    input  logic                   sel_i,
    input  logic                   we_i,
    input  fabricBusPkg::byteStb_t byteStb_i,
    input  fabricBusPkg::regAddr_t wordAddr_i,
    input  fabricBusPkg::busData_t wrData_i,
    input  fabricIdPkg::gpio_t     gpioIn_i,
    output logic                   ack_o,
    output fabricBusPkg::busData_t rdData_o,
    output fabricIdPkg::gpio_t     gpioOut_o,
    output fabricIdPkg::gpio_t     gpioOe_o
);

    import fabricBusPkg::*;
    import fabricIdPkg::*;

    gpio_t gpioMeta;
    gpio_t gpioInReg;
    logic  regWrite;

    // First cycle of a write carrying byte lane 0
    assign regWrite = sel_i & we_i & ~ack_o & byteStb_i[0];

    // ----------------------------------------------------------------------
    // GPIO registers
    // ----------------------------------------------------------------------

    always_ff @(posedge wbClk_i)
    begin
        if (reset_i)
        begin
            gpioOut_o <= gpioOutRstValue;
            gpioOe_o  <= gpioOeRstValue;
        end
        else if (regWrite)
        begin
            case (wordAddr_i)
                gpioOutOfs: gpioOut_o <= wrData_i[gpioWidth-1:0];
                gpioOeOfs:  gpioOe_o  <= wrData_i[gpioWidth-1:0];
                // Other offsets ignore writes
                default:    ;
            endcase
        end
    end

    // Two-stage input synchronizer
    always_ff @(posedge wbClk_i)
    begin
        gpioMeta  <= gpioIn_i;
        gpioInReg <= gpioMeta;
    end

    // Single-cycle acknowledge pulse
    always_ff @(posedge wbClk_i)
    begin
        if (reset_i)
            ack_o <= 1'b0;
        else
            ack_o <= sel_i & ~ack_o;
    end

    // ----------------------------------------------------------------------
    // Read mux, address held by the host
    // ----------------------------------------------------------------------

    always_comb
    begin
        case (wordAddr_i)
            idRegOfs:   rdData_o = fabricIdValue;
            revRegOfs:  rdData_o = fabricRevValue;
            gpioInOfs:  rdData_o = {{(busDataWidth-gpioWidth){1'b0}}, gpioInReg};
            gpioOutOfs: rdData_o = {{(busDataWidth-gpioWidth){1'b0}}, gpioOut_o};
            gpioOeOfs:  rdData_o = {{(busDataWidth-gpioWidth){1'b0}}, gpioOe_o};
            default:    rdData_o = regUndefValue;
        endcase
    end

endmodule

// File: scratchRam.sv
`timescale 1ns/1ps

module scratchRam
(
    input  logic                   wbClk_i,
    input  logic                   sel_i,
    input  logic                   we_i,
    input  fabricBusPkg::byteStb_t byteStb_i,
    input  fabricBusPkg::ramAddr_t wordAddr_i,
    input  fabricBusPkg::busData_t wrData_i,
    input  logic                   reset_i,
    output logic                   ack_o,
    output fabricBusPkg::busData_t rdData_o
);

    import fabricBusPkg::*;

    busData_t mem [ramDepth];
    logic     ramAccess;

    // Only the first cycle of a strobe touches the array
    assign ramAccess = sel_i & ~ack_o;

    // Byte-lane write port
    always_ff @(posedge wbClk_i)
    begin
        if (ramAccess && we_i)
        begin
            for (int lane = 0; lane < byteLanes; lane++)
            begin
                if (byteStb_i[lane])
                    mem[wordAddr_i][8*lane +: 8] <= wrData_i[8*lane +: 8];
            end
        end
    end

    // Read word lands with the acknowledge
    always_ff @(posedge wbClk_i)
    begin
        if (ramAccess)
            rdData_o <= mem[wordAddr_i];
    end

    always_ff @(posedge wbClk_i)
    begin
        if (reset_i)
            ack_o <= 1'b0;
        else
            ack_o <= ramAccess;
    end

endmodule

// File: reservedRegisters.sv
`timescale 1ns/1ps

module reservedRegisters
(
    input  logic                   wbClk_i,
    input  logic                   reset_i,
    input  logic                   sel_i,
    input  fabricBusPkg::regAddr_t wordAddr_i,
    output logic                   ack_o,
    output fabricBusPkg::busData_t rdData_o
);

    import fabricIdPkg::*;

    // Writes land here too, acknowledged and dropped
    always_ff @(posedge wbClk_i)
    begin
        if (reset_i)
            ack_o <= 1'b0;
        else
            ack_o <= sel_i & ~ack_o;
    end

    // ----------------------------------------------------------------------
    // Identification words
    // ----------------------------------------------------------------------

    always_comb
    begin
        case (wordAddr_i)
            // Customer in bits 15:8, product in 7:0
            custProdOfs:  rdData_o = {16'h0000, customerId, productId};
            // Major over minor
            revisionsOfs: rdData_o = {majorRev, minorRev};
            default:      rdData_o = reservedUndefValue;
        endcase
    end

endmodule

// File: fpgaFabricTop.sv
`timescale 1ns/1ps

module fpgaFabricTop
(
    input  logic                   wbClk_i,
    input  logic                   reset_i,
    input  logic                   cyc_i,
    input  logic                   stb_i,
    input  logic                   we_i,
    input  fabricBusPkg::busAddr_t addr_i,
    input  fabricBusPkg::byteStb_t byteStb_i,
    input  fabricBusPkg::busData_t wrData_i,
    input  fabricIdPkg::gpio_t     gpioIn_i,
    output fabricBusPkg::busData_t rdData_o,
    output logic                   ack_o,
    output fabricIdPkg::gpio_t     gpioOut_o,
    output fabricIdPkg::gpio_t     gpioOe_o
);

    import fabricBusPkg::*;

    // Region selects from the decoder
    logic regSel;
    logic ram0Sel;
    logic ram1Sel;
    logic resSel;

    // Per-region acknowledge and read data
    logic     regAck;
    logic     ram0Ack;
    logic     ram1Ack;
    logic     resAck;
    busData_t regData;
    busData_t ram0Data;
    busData_t ram1Data;
    busData_t resData;

    // ----------------------------------------------------------------------
    // Control
    // ----------------------------------------------------------------------

    busDecoder decoder
    (
        .wbClk_i(wbClk_i), .reset_i(reset_i), .cyc_i(cyc_i), .stb_i(stb_i), .addr_i(addr_i),
        .regAck_i(regAck), .ram0Ack_i(ram0Ack), .ram1Ack_i(ram1Ack), .resAck_i(resAck),
        .regData_i(regData), .ram0Data_i(ram0Data), .ram1Data_i(ram1Data),
        .resData_i(resData), .regSel_o(regSel), .ram0Sel_o(ram0Sel), .ram1Sel_o(ram1Sel),
        .resSel_o(resSel), .ack_o(ack_o), .rdData_o(rdData_o)
    );

    // ----------------------------------------------------------------------
    // Datapath, word address from bit 2 up
    // ----------------------------------------------------------------------

    fabricRegisters registers
    (
        .wbClk_i(wbClk_i), .reset_i(reset_i), .sel_i(regSel), .we_i(we_i),
        .byteStb_i(byteStb_i), .wordAddr_i(addr_i[regAddrWidth+1:2]), .wrData_i(wrData_i),
        .gpioIn_i(gpioIn_i), .ack_o(regAck), .rdData_o(regData),
        .gpioOut_o(gpioOut_o), .gpioOe_o(gpioOe_o)
    );

    scratchRam ram0
    (
        .wbClk_i(wbClk_i), .sel_i(ram0Sel), .we_i(we_i), .byteStb_i(byteStb_i),
        .wordAddr_i(addr_i[ramAddrWidth+1:2]), .wrData_i(wrData_i), .reset_i(reset_i),
        .ack_o(ram0Ack), .rdData_o(ram0Data)
    );

    scratchRam ram1
    (
        .wbClk_i(wbClk_i), .sel_i(ram1Sel), .we_i(we_i), .byteStb_i(byteStb_i),
        .wordAddr_i(addr_i[ramAddrWidth+1:2]), .wrData_i(wrData_i), .reset_i(reset_i),
        .ack_o(ram1Ack), .rdData_o(ram1Data)
    );

    reservedRegisters reserved
    (
        .wbClk_i(wbClk_i), .reset_i(reset_i), .sel_i(resSel),
        .wordAddr_i(addr_i[regAddrWidth+1:2]), .ack_o(resAck), .rdData_o(resData)
    );

endmodule

// File: tbFabricCheck.svh
`ifndef TB_FABRIC_CHECK_SVH
`define TB_FABRIC_CHECK_SVH

    // ----------------------------------------------------------------------
    // Reference model state
    // ----------------------------------------------------------------------

    // Mirror of both scratch RAMs, X until written
    busData_t refRam0 [ramDepth];
    busData_t refRam1 [ramDepth];
    gpio_t    refGpioOut;
    gpio_t    refGpioOe;
    // Last value driven on the GPIO input pins
    gpio_t    refGpioIn;

    // Results waiting for the compare process
    busData_t dataGotQ [$];
    busData_t dataExpQ [$];
    string    dataTagQ [$];
    gpio_t    gpioGotQ [$];
    gpio_t    gpioExpQ [$];
    string    gpioTagQ [$];

    // Byte address of a word inside a region
    function automatic busAddr_t makeAddr(input regionSel_t region, input int word);
        return busAddr_t'(int'(region) * (1 << regionLsb) + word * 4);
    endfunction

    // Mapped regions answer at once, the rest wait for the timeout
    function automatic int refLatency(input busAddr_t a);
        regionSel_t region;
        region = a[busAddrWidth-1:regionLsb];
        if (region == regBase || region == ram0Base || region == ram1Base ||
            region == reservedBase)
            return 1;
        return int'(timeoutCount) + 1;
    endfunction

    // Expected read word from the address map rules
    function automatic busData_t refRead(input busAddr_t a);
        regionSel_t region;
        regAddr_t   ofs;
        ramAddr_t   word;
        busData_t   idWord;
        region = a[busAddrWidth-1:regionLsb];
        ofs    = a[regAddrWidth+1:2];
        word   = a[ramAddrWidth+1:2];
        idWord = '0;
        case (region)
            regBase:
            begin
                case (ofs)
                    idRegOfs:   return fabricIdValue;
                    revRegOfs:  return fabricRevValue;
                    gpioInOfs:  return busData_t'(refGpioIn);
                    gpioOutOfs: return busData_t'(refGpioOut);
                    gpioOeOfs:  return busData_t'(refGpioOe);
                    default:    return regUndefValue;
                endcase
            end
            ram0Base:     return refRam0[word];
            ram1Base:     return refRam1[word];
            reservedBase:
            begin
                // Fields placed by bit position
                if (ofs == custProdOfs)
                begin
                    idWord[15:8] = customerId;
                    idWord[7:0]  = productId;
                    return idWord;
                end
                if (ofs == revisionsOfs)
                begin
                    idWord[31:16] = majorRev;
                    idWord[15:0]  = minorRev;
                    return idWord;
                end
                return reservedUndefValue;
            end
            default:      return badAccessValue;
        endcase
    endfunction

    // Apply a write to the model, byte lanes merged
    function automatic void refWrite(input busAddr_t a, input byteStb_t stbs,
                                     input busData_t data);
        regionSel_t region;
        regAddr_t   ofs;
        ramAddr_t   word;
        region = a[busAddrWidth-1:regionLsb];
        ofs    = a[regAddrWidth+1:2];
        word   = a[ramAddrWidth+1:2];
        for (int lane = 0; lane < byteLanes; lane++)
        begin
            if (stbs[lane] && region == ram0Base)
                refRam0[word][8*lane +: 8] = data[8*lane +: 8];
            if (stbs[lane] && region == ram1Base)
                refRam1[word][8*lane +: 8] = data[8*lane +: 8];
        end
        // GPIO only through lane 0
        if (region == regBase && stbs[0] && ofs == gpioOutOfs)
            refGpioOut = data[gpioWidth-1:0];
        if (region == regBase && stbs[0] && ofs == gpioOeOfs)
            refGpioOe = data[gpioWidth-1:0];
    endfunction

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------

    task automatic checkData(input busData_t got, input busData_t exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL at %0d ns: %s gave %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkGpio(input gpio_t got, input gpio_t exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Cycle counts of the handshake
    task automatic checkCount(input int got, input int exp, input string what);
        checks++;
        if (got != exp)
        begin
            errors++;
            $display("FAIL at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

`endif

// File: tbFabricTop.sv
`timescale 1ns/1ps

module tbFabricTop;

    import fabricBusPkg::*;
    import fabricIdPkg::*;

    localparam int ackTimeout = 32;

    logic     wbClk;
    logic     reset;
    logic     cyc;
    logic     stb;
    logic     we;
    busAddr_t addr;
    byteStb_t byteStb;
    busData_t wrData;
    gpio_t    gpioIn;
    busData_t rdData;
    logic     ack;
    gpio_t    gpioOut;
    gpio_t    gpioOe;

    // Galois LFSR state
    logic [15:0] lfsr = 16'd30655;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          failedTests = 0;
    int          testErrBase = 0;
    ramAddr_t    ramWords [8];
    busData_t    scratch;

    `include "tbFabricCheck.svh"

    fpgaFabricTop UUT
    (
        .wbClk_i(wbClk), .reset_i(reset), .cyc_i(cyc), .stb_i(stb), .we_i(we),
        .addr_i(addr), .byteStb_i(byteStb), .wrData_i(wrData), .gpioIn_i(gpioIn),
        .rdData_o(rdData), .ack_o(ack), .gpioOut_o(gpioOut), .gpioOe_o(gpioOe)
    );

    initial
    begin
        wbClk = 1'b0;
        forever
            #20 wbClk = ~wbClk;
    end

    // One LFSR step per bit, taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return val;
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $finish;
    endtask

    // ----------------------------------------------------------------------
    // Host bus cycle, driven on the falling edge
    // ----------------------------------------------------------------------

    task automatic busCycle(input busAddr_t a, input logic wr, input byteStb_t stbs,
                            input busData_t data, output busData_t rd);
        int cycles;
        cycles  = 0;
        cyc     = 1'b1;
        stb     = 1'b1;
        we      = wr;
        addr    = a;
        byteStb = stbs;
        wrData  = data;
        do
        begin
            @(negedge wbClk);
            cycles++;
        end while (!ack && cycles < ackTimeout);
        if (!ack)
            abortRun($sformatf("No acknowledge for address %h after %0d cycles", a, cycles));
        else
        begin
            rd = rdData;
            checkCount(cycles, refLatency(a), $sformatf("ack latency at %h", a));
            cyc = 1'b0;
            stb = 1'b0;
            we  = 1'b0;
            @(negedge wbClk);
            // Pulse must be gone one cycle later
            checkCount(int'(ack !== 1'b0), 0, $sformatf("ack level after pulse at %h", a));
        end
    endtask

    task automatic writeBus(input busAddr_t a, input byteStb_t stbs, input busData_t data);
        busData_t unused;
        busCycle(a, 1'b1, stbs, data, unused);
        refWrite(a, stbs, data);
    endtask

    task automatic readBus(input busAddr_t a);
        busData_t got;
        busCycle(a, 1'b0, 4'hF, '0, got);
        dataGotQ.push_back(got);
        dataExpQ.push_back(refRead(a));
        dataTagQ.push_back($sformatf("read of %h", a));
    endtask

    task automatic queueGpio();
        gpioGotQ.push_back(gpioOut);
        gpioExpQ.push_back(refGpioOut);
        gpioTagQ.push_back("gpioOut_o");
        gpioGotQ.push_back(gpioOe);
        gpioExpQ.push_back(refGpioOe);
        gpioTagQ.push_back("gpioOe_o");
    endtask

    // Waits out the compare process, then reports
    task automatic endTest(input string name);
        @(posedge wbClk);
        @(negedge wbClk);
        tests++;
        if (errors != testErrBase)
        begin
            failedTests++;
            $display("Test %0d %s: failed, %0d errors", tests, name, errors - testErrBase);
        end
        else
            $display("Test %0d %s: passed", tests, name);
        testErrBase = errors;
    endtask

    // Compare process, drains results queued on the falling edge
    always @(posedge wbClk)
    begin
        while (dataGotQ.size() > 0)
            checkData(dataGotQ.pop_front(), dataExpQ.pop_front(), dataTagQ.pop_front());
        while (gpioGotQ.size() > 0)
            checkGpio(gpioGotQ.pop_front(), gpioExpQ.pop_front(), gpioTagQ.pop_front());
    end

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------

    initial
    begin
        reset      = 1'b1;
        cyc        = 1'b0;
        stb        = 1'b0;
        we         = 1'b0;
        addr       = '0;
        byteStb    = '0;
        wrData     = '0;
        gpioIn     = '0;
        refGpioIn  = '0;
        // GPIO outputs and enables come out of reset cleared
        refGpioOut = '0;
        refGpioOe  = '0;
        repeat (3)
            @(posedge wbClk);
        @(negedge wbClk);
        reset = 1'b0;

        // Reset state and identification
        queueGpio();
        readBus(makeAddr(regBase, idRegOfs));
        readBus(makeAddr(regBase, revRegOfs));
        endTest("reset and identification");

        // GPIO out and enable, then a write without lane 0
        for (int i = 0; i < 4; i++)
        begin
            writeBus(makeAddr(regBase, gpioOutOfs), 4'hF, randBits(32));
            writeBus(makeAddr(regBase, gpioOeOfs), 4'hF, randBits(32));
            queueGpio();
            readBus(makeAddr(regBase, gpioOutOfs));
            readBus(makeAddr(regBase, gpioOeOfs));
        end
        writeBus(makeAddr(regBase, gpioOutOfs), 4'hE, randBits(32));
        queueGpio();
        gpioIn    = gpio_t'(randBits(gpioWidth));
        refGpioIn = gpioIn;
        // Synchronizer settling
        repeat (4)
            @(negedge wbClk);
        readBus(makeAddr(regBase, gpioInOfs));
        endTest("GPIO");

        // Same word offsets in both RAMs, full then partial writes
        for (int i = 0; i < 8; i++)
        begin
            ramWords[i] = ramAddr_t'(randBits(ramAddrWidth));
            writeBus(makeAddr(ram0Base, ramWords[i]), 4'hF, randBits(32));
            writeBus(makeAddr(ram1Base, ramWords[i]), 4'hF, randBits(32));
        end
        for (int i = 0; i < 8; i++)
        begin
            writeBus(makeAddr(ram0Base, ramWords[i]), byteStb_t'(randBits(4)), randBits(32));
            writeBus(makeAddr(ram1Base, ramWords[i]), byteStb_t'(randBits(4)), randBits(32));
        end
        for (int i = 0; i < 8; i++)
        begin
            readBus(makeAddr(ram0Base, ramWords[i]));
            readBus(makeAddr(ram1Base, ramWords[i]));
        end
        endTest("scratch RAMs");

        // Reserved block, write ignored
        writeBus(makeAddr(reservedBase, custProdOfs), 4'hF, randBits(32));
        readBus(makeAddr(reservedBase, custProdOfs));
        readBus(makeAddr(reservedBase, revisionsOfs));
        for (int i = 0; i < 3; i++)
            readBus(makeAddr(reservedBase, randBits(regAddrWidth) % 126));
        endTest("reserved block");

        // Undefined offset, then unmapped regions through the timeout
        scratch = 5 + randBits(regAddrWidth) % 123;
        writeBus(makeAddr(regBase, scratch), 4'hF, randBits(32));
        readBus(makeAddr(regBase, scratch));
        readBus(makeAddr(regionSel_t'(3), randBits(ramAddrWidth)));
        writeBus(makeAddr(regionSel_t'(5 + randBits(4) % 11), 0), 4'hF, randBits(32));
        readBus(makeAddr(regionSel_t'(5 + randBits(4) % 11), randBits(ramAddrWidth)));
        endTest("undefined and unmapped");

        // Mixed mapped traffic, latency and pulse checked per cycle
        for (int i = 0; i < 8; i++)
        begin
            writeBus(makeAddr(ram1Base, ramWords[i]), byteStb_t'(randBits(4)), randBits(32));
            readBus(makeAddr(ram0Base, ramWords[randBits(3)]));
            readBus(makeAddr(regBase, randBits(3)));
            readBus(makeAddr(reservedBase, custProdOfs + randBits(1)));
            readBus(makeAddr(ram1Base, ramWords[i]));
        end
        endTest("acknowledge timing");

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failedTests, checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+.
fabricBusPkg.sv
fabricIdPkg.sv
busDecoder.sv
fabricRegisters.sv
scratchRam.sv
reservedRegisters.sv
fpgaFabricTop.sv
tbFabricTop.sv
